// ==== rtl/an_arbiter.sv ====
// Auto-negotiation arbitration FSM
// Walks restart, ability, ack, idle and link ok, falls back to abort
// once the watchdog has disabled negotiation. Builds the transmitted
// configuration word and the registered status vector
`timescale 1ns/100ps

module an_arbiter import an_pkg::*; (
   input  logic        rx_clk,
   input  logic        an_rst,
   input  logic        los,
   lacr_obs_if.arbiter obs,
   input  logic        timer_on,
   input  logic        timer_done,
   input  logic        wdog_timeout,
   input  logic        wdog_disable,
   output logic        timer_start,
   output logic        progress,
   output lacr_t       lacr_out,
   output logic        lacr_send,
   output logic        operate,
   output an_status_t  an_status
);

   an_state_t  state;
   an_state_t  state_nxt;
   logic       force_restart;
   logic       timer_idle;
   logic       abl_hit;
   logic       ack_hit;
   logic       abl_match;
   logic       ack_match;
   logic       consistency_match;
   lacr_t      lacr_ability;
   lacr_t      word_c;
   logic       send_c;
   logic       operate_c;
   an_status_t status_c;

   // Breaklink is ignored once the watchdog has given up
   assign force_restart = los || wdog_timeout ||
                          (obs.breaklink_restart && !wdog_disable);

   // Matching only runs outside restart
   assign obs.filter_enable = (state != AN_RESTART);

   // Neither running nor just expired
   assign timer_idle = !timer_on && !timer_done;

   // Partner ability word, three in a row without ack
   assign abl_hit = (state == AN_ABILITY) && obs.match_ok &&
                    !obs.match_word[LACR_ACK_BIT];
   // Partner acknowledge, first one only
   assign ack_hit = (state == AN_ACK) && obs.match_ok &&
                    obs.match_word[LACR_ACK_BIT] && !ack_match;

   // Next state and timer kicks
   always_comb begin
      state_nxt   = state;
      timer_start = 1'b0;
      case (state)
         AN_RESTART: begin
            timer_start = timer_idle;
            if (timer_done && obs.link_det) begin
               state_nxt = wdog_disable ? AN_ABORT : AN_ABILITY;
            end
         end
         AN_ABILITY: begin
            if (abl_match) begin
               state_nxt = AN_ACK;
            end
         end
         AN_ACK: begin
            timer_start = timer_idle;
            // Acked word must agree with what was latched
            if (timer_done && ack_match) begin
               state_nxt = consistency_match ? AN_IDLE : AN_RESTART;
            end
         end
         AN_IDLE: begin
            // Idle check always passes
            timer_start = timer_idle;
            if (timer_done) begin
               state_nxt = AN_LINK_OK;
            end
         end
         AN_LINK_OK: state_nxt = AN_LINK_OK;
         AN_ABORT:   state_nxt = AN_ABORT;
         default:    state_nxt = AN_RESTART;
      endcase
      if (force_restart) begin
         state_nxt = AN_RESTART;
      end
   end

   // Forward moves out of restart do not count
   assign progress = (state != AN_RESTART) && (state_nxt > state);

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         state <= AN_RESTART;
      end else begin
         state <= state_nxt;
      end
   end

   // Ability, ack and consistency flags
   // Cleared whenever the FSM is in or is forced to restart
   always_ff @(posedge rx_clk) begin
      if (an_rst || force_restart || state == AN_RESTART) begin
         abl_match         <= 1'b0;
         ack_match         <= 1'b0;
         consistency_match <= 1'b0;
      end else begin
         if (abl_hit) begin
            abl_match <= 1'b1;
         end
         if (ack_hit) begin
            ack_match         <= 1'b1;
            consistency_match <= (obs.match_word == lacr_ability);
         end
      end
   end

   // Latched partner ability
   // Ack bit forced so the later compare is against the acked form
   always_ff @(posedge rx_clk) begin
      if (abl_hit) begin
         lacr_ability               <= obs.match_word;
         lacr_ability[LACR_ACK_BIT] <= 1'b1;
      end
   end

   // Output values for the current state
   always_comb begin
      send_c    = (state == AN_RESTART) || (state == AN_ABILITY) ||
                  (state == AN_ACK);
      operate_c = (state == AN_LINK_OK) || (state == AN_ABORT);

      // Breaklink in restart, own ability elsewhere
      word_c = LACR_LOCAL_ABILITY;
      word_c[LACR_ACK_BIT] = (state == AN_ACK) || (state == AN_IDLE);
      if (state == AN_RESTART) begin
         word_c = '0;
      end

      status_c              = '0;
      status_c.abort        = (state == AN_ABORT);
      status_c.ability      = (state == AN_ABILITY);
      status_c.wdog_disable = wdog_disable;
      status_c.rf           = {obs.match_word[LACR_RF2_BIT], obs.match_word[LACR_RF1_BIT]};
      status_c.abl_mismatch = abl_match && !lacr_ability[LACR_FD_BIT];
      status_c.ack          = (state == AN_ACK);
      status_c.idle         = (state == AN_IDLE);
      status_c.link_ok      = (state == AN_LINK_OK);
   end

   // Registered outputs, one cycle behind the state
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_send <= 1'b0;
         operate   <= 1'b0;
         an_status <= '0;
      end else begin
         lacr_send <= send_c;
         operate   <= operate_c;
         an_status <= status_c;
      end
   end

   // Transmit word
   always_ff @(posedge rx_clk) begin
      lacr_out <= word_c;
   end

endmodule

// ==== rtl/an_pkg.sv ====
// Shared definitions for the Clause 37 auto-negotiation block
// Link configuration word layout, arbitration states and the
// packed status vector reported to the outside
package an_pkg;

   // Bit positions inside the 16-bit configuration word
   localparam int LACR_NP_BIT  = 15;
   localparam int LACR_ACK_BIT = 14;
   localparam int LACR_RF2_BIT = 13;
   localparam int LACR_RF1_BIT = 12;
   localparam int LACR_HD_BIT  = 6;
   localparam int LACR_FD_BIT  = 5;

   // One link configuration word
   typedef logic [15:0] lacr_t;

   // Clears the ack bit so words compare on content only
   localparam lacr_t LACR_ACK_MASK = 16'hbfff;

   // What this station advertises, full duplex and nothing else
   localparam lacr_t LACR_LOCAL_ABILITY = 16'h0020;

   // Arbitration states
   // Numeric order matters, a higher value is forward progress
   typedef enum logic [2:0] {
      AN_RESTART = 3'd0,
      AN_ABILITY = 3'd1,
      AN_ACK     = 3'd2,
      AN_IDLE    = 3'd3,
      AN_LINK_OK = 3'd4,
      AN_ABORT   = 3'd5
   } an_state_t;

   // Status vector, 9 bits, top bit first
   typedef struct packed {
      logic       abort;
      logic       ability;
      logic       wdog_disable;
      logic [1:0] rf;            // {RF2, RF1} of the last received word
      logic       abl_mismatch;  // Partner did not offer full duplex
      logic       ack;
      logic       idle;
      logic       link_ok;
   } an_status_t;

endpackage

// ==== rtl/an_timers.sv ====
// Auto-negotiation timers
// Link timer for the restart, ack and idle phases, and a watchdog
// that disables negotiation when no forward progress is made
`timescale 1ns/100ps

module an_timers #(
   parameter int TIMER_TICKS = 1250000,
   parameter int WDOG_MULT   = 8
) (
   input  logic rx_clk,
   input  logic an_rst,
   input  logic los,
   input  logic link_det,
   input  logic link_ok,
   input  logic timer_start,
   input  logic progress,
   output logic timer_on,
   output logic timer_done,
   output logic wdog_timeout,
   output logic wdog_disable
);

   localparam int TIMER_W    = $clog2(TIMER_TICKS + 1);
   localparam int WDOG_TICKS = TIMER_TICKS * WDOG_MULT;
   localparam int WDOG_W     = $clog2(WDOG_TICKS + 1);

   logic [TIMER_W-1:0] link_cnt;
   logic [WDOG_W-1:0]  wdog_cnt;

   // Link timer, loads on start and counts down
   // done fires TIMER_TICKS cycles after the start pulse
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         link_cnt   <= '0;
         timer_on   <= 1'b0;
         timer_done <= 1'b0;
      end else begin
         timer_done <= 1'b0;
         if (timer_start) begin
            link_cnt <= TIMER_W'(TIMER_TICKS);
            timer_on <= 1'b1;
         end else if (timer_on) begin
            link_cnt <= link_cnt - 1'b1;
            if (link_cnt == TIMER_W'(1)) begin
               timer_done <= 1'b1;
               timer_on   <= 1'b0;
            end
         end
      end
   end

   // Watchdog
   // Runs while a partner is present and link is not up
   // Freezes once it has tripped, until progress or los
   always_ff @(posedge rx_clk) begin
      if (an_rst || progress || los) begin
         wdog_cnt     <= '0;
         wdog_timeout <= 1'b0;
         wdog_disable <= 1'b0;
      end else begin
         wdog_timeout <= 1'b0;
         if (link_det && !link_ok && !wdog_disable) begin
            wdog_cnt <= wdog_cnt + 1'b1;
            // Last tick, trip once and give up on negotiation
            if (wdog_cnt == WDOG_W'(WDOG_TICKS - 1)) begin
               wdog_timeout <= 1'b1;
               wdog_disable <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== rtl/an_top.sv ====
// 1000BASE-X auto-negotiation top level
// Receive filter, link timer with watchdog, and the arbitration FSM
// Partner words come in as strobes, own word and status go out
`timescale 1ns/100ps

module an_top import an_pkg::*; #(
   parameter int TIMER_TICKS = 1250000,
   parameter int WDOG_MULT   = 8
) (
   input  logic       rx_clk,
   input  logic       an_rst,
   input  logic       los,
   input  lacr_t      lacr_in,
   input  logic       lacr_in_stb,
   output lacr_t      lacr_out,
   output logic       lacr_send,
   output logic       operate,
   output logic [8:0] an_status
);

   // FSM to timer links
   logic       timer_start;
   logic       progress;
   logic       timer_on;
   logic       timer_done;
   logic       wdog_timeout;
   logic       wdog_disable;
   an_status_t status;

   lacr_obs_if obs ();

   assign an_status = status;

   lacr_rx_filter filter0 (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .los         (los),
      .lacr_in     (lacr_in),
      .lacr_in_stb (lacr_in_stb),
      .obs         (obs.filter)
   );

   // Watchdog stops once the status shows link ok
   an_timers #(
      .TIMER_TICKS (TIMER_TICKS),
      .WDOG_MULT   (WDOG_MULT)
   ) timers0 (
      .rx_clk       (rx_clk),
      .an_rst       (an_rst),
      .los          (los),
      .link_det     (obs.link_det),
      .link_ok      (status.link_ok),
      .timer_start  (timer_start),
      .progress     (progress),
      .timer_on     (timer_on),
      .timer_done   (timer_done),
      .wdog_timeout (wdog_timeout),
      .wdog_disable (wdog_disable)
   );

   an_arbiter arb0 (
      .rx_clk       (rx_clk),
      .an_rst       (an_rst),
      .los          (los),
      .obs          (obs.arbiter),
      .timer_on     (timer_on),
      .timer_done   (timer_done),
      .wdog_timeout (wdog_timeout),
      .wdog_disable (wdog_disable),
      .timer_start  (timer_start),
      .progress     (progress),
      .lacr_out     (lacr_out),
      .lacr_send    (lacr_send),
      .operate      (operate),
      .an_status    (status)
   );

endmodule

// ==== rtl/lacr_obs_if.sv ====
// Receive observation bundle
// Carries what the receive filter sees on the partner's configuration
// words over to the arbitration FSM, plus the enable coming back
`timescale 1ns/100ps

interface lacr_obs_if import an_pkg::*; ();

   // Partner is sending something
   logic  link_det;
   // One-cycle pulse, three matching words in a row
   logic  match_ok;
   // Most recent word received
   lacr_t match_word;
   // Level, partner sending breaklink
   logic  breaklink_restart;
   // Low while the FSM sits in restart
   logic  filter_enable;

   modport filter (
      output link_det,
      output match_ok,
      output match_word,
      output breaklink_restart,
      input  filter_enable
   );

   modport arbiter (
      input  link_det,
      input  match_ok,
      input  match_word,
      input  breaklink_restart,
      output filter_enable
   );

endinterface

// ==== rtl/lacr_rx_filter.sv ====
// Receive filter for partner configuration words
// Detects link, finds three consecutive matching words with the ack bit
// ignored, and spots the all-zero breaklink pattern
`timescale 1ns/100ps

module lacr_rx_filter import an_pkg::*; (
   input  logic       rx_clk,
   input  logic       an_rst,
   input  logic       los,
   input  lacr_t      lacr_in,
   input  logic       lacr_in_stb,
   lacr_obs_if.filter obs
);

   lacr_t      prev_word;
   logic       same_c;
   logic       word_match;
   logic       word_change;
   logic [1:0] match_cnt;
   logic [1:0] zero_cnt;

   // Content compare, ack bit masked off
   assign same_c = (prev_word & LACR_ACK_MASK) == (lacr_in & LACR_ACK_MASK);

   // Any strobe means a partner is there
   // los wins over a strobe in the same cycle
   always_ff @(posedge rx_clk) begin
      if (an_rst || los) begin
         obs.link_det <= 1'b0;
      end else if (lacr_in_stb) begin
         obs.link_det <= 1'b1;
      end
   end

   // Last word seen, also feeds the rf status bits
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         prev_word <= '0;
      end else if (lacr_in_stb) begin
         prev_word <= lacr_in;
      end
   end

   assign obs.match_word = prev_word;

   // Registered compare, then the run counter
   // Held clear while the FSM is in restart
   always_ff @(posedge rx_clk) begin
      if (an_rst || !obs.filter_enable) begin
         word_match   <= 1'b0;
         word_change  <= 1'b0;
         match_cnt    <= 2'd0;
         obs.match_ok <= 1'b0;
      end else begin
         word_match   <= lacr_in_stb && same_c;
         word_change  <= lacr_in_stb && !same_c;
         obs.match_ok <= 1'b0;
         if (word_change) begin
            match_cnt <= 2'd0;
         end else if (word_match) begin
            // Third match in a row, report and start over
            if (match_cnt == 2'd2) begin
               match_cnt    <= 2'd0;
               obs.match_ok <= 1'b1;
            end else begin
               match_cnt <= match_cnt + 2'd1;
            end
         end
      end
   end

   // Zero-word run, saturates so breaklink stays a level
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         zero_cnt <= 2'd0;
      end else if (lacr_in_stb) begin
         if (lacr_in != '0) begin
            zero_cnt <= 2'd0;
         end else if (zero_cnt != 2'd3) begin
            zero_cnt <= zero_cnt + 2'd1;
         end
      end
   end

   assign obs.breaklink_restart = (zero_cnt == 2'd3);

endmodule

// ==== tb.f ====
+incdir+tests
rtl/an_pkg.sv
rtl/lacr_obs_if.sv
rtl/lacr_rx_filter.sv
rtl/an_timers.sv
rtl/an_arbiter.sv
rtl/an_top.sv
tests/tb_an_top.sv

// ==== tests/tb_an_checks.svh ====
// Compare tasks, bounded waits and directed tests
// Included into the auto-negotiation testbench module

   // Status bit masks with abort on top and link_ok at the bottom
   localparam an_status_t ST_NONE     = 9'h000;
   localparam an_status_t ST_ALL      = 9'h1ff;
   localparam an_status_t ST_ABORT    = 9'h100;
   localparam an_status_t ST_ABILITY  = 9'h080;
   localparam an_status_t ST_WDOG     = 9'h040;
   localparam an_status_t ST_RF       = 9'h030;
   localparam an_status_t ST_ACK      = 9'h004;
   localparam an_status_t ST_IDLE     = 9'h002;
   localparam an_status_t ST_LINK_OK  = 9'h001;
   // All state bits
   // None set means restart
   localparam an_status_t ST_STATES   = 9'h187;

   localparam lacr_t ACK_BIT_WORD = 16'h0001 << LACR_ACK_BIT;

   task automatic word_equal(input lacr_t got, input lacr_t exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // Only the bits under mask are compared
   task automatic status_equal(input an_status_t got, input an_status_t exp,
                               input an_status_t mask, input string what);
      if ((got & mask) !== (exp & mask)) begin
         value_errors++;
         $display("FAILED at %0t: %s, got %h expected %h", $time, what,
                  got & mask, exp & mask);
      end
   endtask

   task automatic bit_equal(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   // Poll the status each cycle until the masked bits read want
   task automatic wait_status(input an_status_t mask, input an_status_t want,
                              input int limit, input string what);
      int n;
      n = 0;
      while ((st_view & mask) !== want && n < limit) begin
         step_clock();
         n++;
      end
      if ((st_view & mask) !== want) begin
         timeout_errors++;
         $display("Timeout at %0t: %s not reached within %0d cycles", $time, what, limit);
      end
   endtask

   // Partner silent while los is pulsed to force restart and clear the watchdog
   task automatic los_restart(input int hold);
      partner_on = 1'b0;
      los = 1'b1;
      repeat (hold) step_clock();
      los = 1'b0;
   endtask

   // Full walk from restart to link ok with a consistent ack
   task automatic run_negotiation(input lacr_t abl, input logic mismatch);
      lacr_t ack_word;
      ack_word = abl | ACK_BIT_WORD;
      send_words(abl, 1);
      wait_status(ST_ABILITY, ST_ABILITY, 8 * TICKS, "ability state");
      wait_status(ST_ACK, ST_ACK, 4 * TICKS, "ack state");
      word_equal(lacr_out, 16'h4020, "own word in ack");
      bit_equal(lacr_send, 1'b1, "lacr_send in ack");
      bit_equal(st_view.abl_mismatch, mismatch, "abl_mismatch in ack");
      send_words(ack_word, 1);
      wait_status(ST_IDLE, ST_IDLE, 6 * TICKS, "idle state");
      wait_status(ST_LINK_OK, ST_LINK_OK, 3 * TICKS, "link ok state");
      bit_equal(operate, 1'b1, "operate at link ok");
      bit_equal(lacr_send, 1'b0, "lacr_send at link ok");
      bit_equal(st_view.abl_mismatch, mismatch, "abl_mismatch at link ok");
   endtask

   task automatic reset_and_restart();
      step_clock();
      step_clock();
      bit_equal(lacr_send, 1'b1, "lacr_send after reset");
      word_equal(lacr_out, 16'h0000, "breaklink word after reset");
      bit_equal(operate, 1'b0, "operate after reset");
      status_equal(st_view, ST_NONE, ST_ALL, "status after reset");
      // No partner, so restart holds past a timer length
      repeat (2 * TICKS) step_clock();
      status_equal(st_view, ST_NONE, ST_ALL, "status with no partner");
      bit_equal(lacr_send, 1'b1, "lacr_send with no partner");
   endtask

   task automatic normal_negotiation();
      run_negotiation(16'h0020, 1'b0);
   endtask

   task automatic inconsistent_ack();
      los_restart(4);
      status_equal(st_view, ST_NONE, ST_STATES, "restart after los");
      send_words(16'h0020, 1);
      wait_status(ST_ABILITY, ST_ABILITY, 8 * TICKS, "ability state");
      wait_status(ST_ACK, ST_ACK, 4 * TICKS, "ack state");
      // Acked word carries half duplex too
      send_words(16'h4060, 1);
      wait_status(ST_STATES, ST_NONE, 6 * TICKS, "restart on bad ack");
      word_equal(lacr_out, 16'h0000, "breaklink word after bad ack");
      bit_equal(lacr_send, 1'b1, "lacr_send after bad ack");
      // Half duplex only so a mismatch is expected
      run_negotiation(16'h0040, 1'b1);
   endtask

   task automatic breaklink_return();
      send_words(16'h0000, 3);
      wait_status(ST_STATES, ST_NONE, 4 * TICKS, "restart on breaklink");
      bit_equal(operate, 1'b0, "operate after breaklink");
      bit_equal(lacr_send, 1'b1, "lacr_send after breaklink");
      run_negotiation(16'h0020, 1'b0);
   endtask

   task automatic loss_of_signal();
      logic       left_restart;
      lacr_t      rf_word;
      an_status_t rf_exp;
      partner_on = 1'b0;
      los = 1'b1;
      wait_status(ST_STATES, ST_NONE, 8, "restart on los");
      bit_equal(operate, 1'b0, "operate under los");
      left_restart = 1'b0;
      repeat (4 * TICKS) begin
         step_clock();
         if ((st_view & ST_STATES) != ST_NONE || lacr_send !== 1'b1) begin
            left_restart = 1'b1;
         end
      end
      bit_equal(left_restart, 1'b0, "left restart while los held");
      los = 1'b0;
      // Both remote fault bits plus full duplex
      rf_word   = 16'h3020;
      rf_exp    = '0;
      rf_exp.rf = 2'b11;
      send_words(rf_word, 2);
      step_clock();
      step_clock();
      status_equal(st_view, rf_exp, ST_RF, "rf bits from partner");
      partner_on = 1'b0;
   endtask

   task automatic watchdog_abort();
      los_restart(4);
      // Every word differs, so no match can ever occur
      partner_rand = 1'b1;
      partner_on   = 1'b1;
      wait_status(ST_WDOG, ST_WDOG, (MULT + 2) * TICKS, "watchdog disable");
      wait_status(ST_ABORT, ST_ABORT, 4 * TICKS, "abort state");
      bit_equal(operate, 1'b1, "operate in abort");
      bit_equal(lacr_send, 1'b0, "lacr_send in abort");
      status_equal(st_view, ST_WDOG, ST_WDOG, "wdog_disable in abort");
      partner_on = 1'b0;
   endtask

// ==== tests/tb_an_top.sv ====
// Testbench for the 1000BASE-X auto-negotiation top level
// Clock, reset, a link partner model on the receive side and the
// directed test sequence with its closing report
`timescale 1ns/100ps

module tb_an_top import an_pkg::*; ();

   // Short timers so a full negotiation fits in a few hundred cycles
   localparam int TICKS = 32;
   localparam int MULT  = 8;

   logic       rx_clk;
   logic       an_rst;
   logic       los;
   lacr_t      lacr_in;
   logic       lacr_in_stb;
   lacr_t      lacr_out;
   logic       lacr_send;
   logic       operate;
   logic [8:0] an_status;
   an_status_t st_view;

   // Partner model
   logic  partner_on;
   logic  partner_rand;
   lacr_t partner_word;
   lacr_t last_sent;
   int    phase;
   int    sent_cnt;

   int value_errors;
   int timeout_errors;
   int seed_dummy;

   assign st_view = an_status;

   an_top #(
      .TIMER_TICKS (TICKS),
      .WDOG_MULT   (MULT)
   ) dut0 (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .los         (los),
      .lacr_in     (lacr_in),
      .lacr_in_stb (lacr_in_stb),
      .lacr_out    (lacr_out),
      .lacr_send   (lacr_send),
      .operate     (operate),
      .an_status   (an_status)
   );

   initial begin
      rx_clk = 1'b0;
      forever #2 rx_clk = ~rx_clk;
   end

   `include "tb_an_checks.svh"

   // Random word, never zero and never equal to prev outside the ack bit
   function automatic lacr_t pick_random_word(input lacr_t prev);
      lacr_t w;
      w = lacr_t'($urandom);
      w[0] = 1'b1;
      if ((w & LACR_ACK_MASK) == (prev & LACR_ACK_MASK)) begin
         w[1] = ~w[1];
      end
      return w;
   endfunction

   // One cycle, inputs change on the falling edge
   // Partner strobes a word every fourth cycle while it is on
   task automatic step_clock();
      @(negedge rx_clk);
      lacr_in_stb = 1'b0;
      if (partner_on && phase == 0) begin
         if (partner_rand) begin
            lacr_in = pick_random_word(last_sent);
         end else begin
            lacr_in = partner_word;
         end
         lacr_in_stb = 1'b1;
         last_sent   = lacr_in;
         sent_cnt++;
      end
      phase = (phase + 1) % 4;
   endtask

   // Partner sends word count times and then keeps repeating it
   task automatic send_words(input lacr_t word, input int count);
      int target;
      int n;
      partner_word = word;
      partner_rand = 1'b0;
      partner_on   = 1'b1;
      target = sent_cnt + count;
      n = 0;
      while (sent_cnt < target && n < 4 * count + 4) begin
         step_clock();
         n++;
      end
   endtask

   initial begin
      seed_dummy     = $urandom(32'h29a91d7c);
      an_rst         = 1'b1;
      los            = 1'b0;
      lacr_in        = '0;
      lacr_in_stb    = 1'b0;
      partner_on     = 1'b0;
      partner_rand   = 1'b0;
      partner_word   = '0;
      last_sent      = '0;
      phase          = 0;
      sent_cnt       = 0;
      value_errors   = 0;
      timeout_errors = 0;
      repeat (3) @(negedge rx_clk);
      an_rst = 1'b0;

      reset_and_restart();
      normal_negotiation();
      inconsistent_ack();
      breaklink_return();
      loss_of_signal();
      watchdog_abort();

      $display("Summary: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
